// File: design/lc3b_alu.sv
`timescale 1ns/1ps
`include "lc3b_macros.svh"

module lc3b_alu
(
	input  lc3b_pkg::lc3b_aluop   aluop,
	input  logic [`LC3B_WORD-1:0] a,
	input  logic [`LC3B_WORD-1:0] b,
	output logic [`LC3B_WORD-1:0] f
);

	logic [`LC3B_SHAMT-1:0] shamt; // only the low nibble of b shifts

	assign shamt = b[`LC3B_SHAMT-1:0];

	always_comb
	begin
		case (aluop)
			lc3b_pkg::alu_add:
			begin
				f = a + b; // wraps, no carry out
			end
			lc3b_pkg::alu_and:
			begin
				f = a & b;
			end
			lc3b_pkg::alu_not:
			begin
				f = ~a; // b ignored
			end
			lc3b_pkg::alu_pass:
			begin
				f = b;
			end
			lc3b_pkg::alu_sll:
			begin
				f = a << shamt;
			end
			lc3b_pkg::alu_srl:
			begin
				f = a >> shamt; // zero fill
			end
			lc3b_pkg::alu_sra:
			begin
				f = $signed(a) >>> shamt; // sign fill
			end
			default:
			begin
				// mult and div come from the multicycle unit instead
				f = `LC3B_ZERO;
			end
		endcase
	end

endmodule : lc3b_alu

// File: design/lc3b_div_mult_unit.sv
`timescale 1ns/1ps
`include "lc3b_macros.svh"

module lc3b_div_mult_unit
(
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  valid,
	input  lc3b_pkg::lc3b_aluop   aluop,
	input  logic [`LC3B_WORD-1:0] sr1,
	input  logic [`LC3B_WORD-1:0] sr2,
	input  logic                  flow,
	output logic [`LC3B_WORD-1:0] solution,
	output logic                  stall
);

	lc3b_pkg::muldiv_state state;      // sequencer state
	lc3b_pkg::muldiv_state state_next;

	logic [`LC3B_WORD-1:0] mag_a;      // sr1 magnitude for mult, divisor for div
	logic [`LC3B_WORD-1:0] mag_a_next;
	logic [`LC3B_WORD-1:0] mag_b;      // sr2 countdown for mult, remaining dividend for div
	logic [`LC3B_WORD-1:0] mag_b_next;
	logic [`LC3B_WORD-1:0] acc;        // unsigned product or quotient
	logic [`LC3B_WORD-1:0] acc_next;

	logic [`LC3B_WORD-1:0] sr1_mag;    // |sr1|
	logic [`LC3B_WORD-1:0] sr2_mag;    // |sr2|
	logic is_mult;
	logic is_div;
	logic active;                      // a multicycle op sits in id/ex
	logic iter_end;                    // loop exit test for the current op
	logic neg_result;                  // operand signs differ
	logic calc_done;                   // completing this cycle

	assign is_mult = (aluop == lc3b_pkg::alu_mult);
	assign is_div = (aluop == lc3b_pkg::alu_div);
	assign active = valid && (is_mult || is_div);

	// 0x8000 stays 0x8000, which still reads right as an unsigned magnitude
	assign sr1_mag = sr1[`LC3B_WORD-1] ? -sr1 : sr1;
	assign sr2_mag = sr2[`LC3B_WORD-1] ? -sr2 : sr2;

	// mult stops when the countdown empties, div when the remainder is below the divisor
	assign iter_end = is_mult ? (mag_b == `LC3B_ZERO) : (mag_b < mag_a);

	assign neg_result = sr1[`LC3B_WORD-1] ^ sr2[`LC3B_WORD-1];
	assign solution = neg_result ? -acc : acc; // zero stays zero when negated

	// freeze the stage until the op has finished and the hazard unit lets it go
	assign stall = active && !calc_done;

	always_comb
	begin
		state_next = state;
		mag_a_next = mag_a;
		mag_b_next = mag_b;
		acc_next = acc;
		calc_done = 1'b0;

		if (active)
		begin
			case (state)
				lc3b_pkg::st_load:
				begin
					mag_a_next = is_div ? sr2_mag : sr1_mag;
					mag_b_next = is_div ? sr1_mag : sr2_mag;
					acc_next = `LC3B_ZERO; // fresh accumulator
					if (is_div && (sr2 == `LC3B_ZERO))
					begin
						state_next = lc3b_pkg::st_done; // divide by zero, quotient 0
					end
					else
					begin
						state_next = lc3b_pkg::st_iterate;
					end
				end
				lc3b_pkg::st_iterate:
				begin
					if (iter_end)
					begin
						state_next = lc3b_pkg::st_done; // extra cycle just to see the end
					end
					else if (is_mult)
					begin
						acc_next = acc + mag_a;     // repeated addition
						mag_b_next = mag_b - 1'b1;  // one fewer to add
					end
					else
					begin
						mag_b_next = mag_b - mag_a; // repeated subtraction
						acc_next = acc + 1'b1;      // count the subtraction
					end
				end
				lc3b_pkg::st_done:
				begin
					if (flow)
					begin
						calc_done = 1'b1;                 // drop stall, result sampled now
						state_next = lc3b_pkg::st_load;   // ready for the next op
					end
				end
				default:
				begin
					state_next = lc3b_pkg::st_load;
				end
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state <= lc3b_pkg::st_load;
		end
		else
		begin
			state <= state_next;
		end
	end

	// working registers, always loaded before they are read
	always_ff @(posedge clk)
	begin
		mag_a <= mag_a_next;
		mag_b <= mag_b_next;
		acc <= acc_next;
	end

endmodule : lc3b_div_mult_unit

// File: design/lc3b_execute_top.sv
`timescale 1ns/1ps
`include "lc3b_macros.svh"

module lc3b_execute_top
(
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    in_valid,
	input  lc3b_pkg::lc3b_aluop     in_aluop,
	input  logic [`LC3B_WORD-1:0]   in_sr1,
	input  logic [`LC3B_WORD-1:0]   in_sr2,
	input  logic [`LC3B_REGNUM-1:0] in_dest,
	input  logic                    flow,
	output logic                    out_valid,
	output logic [`LC3B_WORD-1:0]   out_result,
	output logic [`LC3B_REGNUM-1:0] out_dest,
	output logic                    stall
);

	logic ex_valid;
	lc3b_pkg::lc3b_aluop ex_aluop;
	logic [`LC3B_WORD-1:0] ex_sr1;
	logic [`LC3B_WORD-1:0] ex_sr2;
	logic [`LC3B_REGNUM-1:0] ex_dest;
	logic [`LC3B_WORD-1:0] alu_result;   // single-cycle path
	logic [`LC3B_WORD-1:0] md_result;    // multicycle path

	lc3b_idex_reg i_idex_reg
	(
		.clk      (clk),
		.rst_n    (rst_n),
		.in_valid (in_valid),
		.in_aluop (in_aluop),
		.in_sr1   (in_sr1),
		.in_sr2   (in_sr2),
		.in_dest  (in_dest),
		.stall    (stall),
		.ex_valid (ex_valid),
		.ex_aluop (ex_aluop),
		.ex_sr1   (ex_sr1),
		.ex_sr2   (ex_sr2),
		.ex_dest  (ex_dest)
	);

	lc3b_alu i_alu
	(
		.aluop (ex_aluop),
		.a     (ex_sr1),
		.b     (ex_sr2),
		.f     (alu_result)
	);

	lc3b_div_mult_unit i_div_mult_unit
	(
		.clk      (clk),
		.rst_n    (rst_n),
		.valid    (ex_valid),
		.aluop    (ex_aluop),
		.sr1      (ex_sr1),
		.sr2      (ex_sr2),
		.flow     (flow),     // from the external hazard unit
		.solution (md_result),
		.stall    (stall)     // freezes id/ex and ex/mem
	);

	lc3b_exmem_reg i_exmem_reg
	(
		.clk        (clk),
		.rst_n      (rst_n),
		.ex_valid   (ex_valid),
		.ex_aluop   (ex_aluop),
		.ex_dest    (ex_dest),
		.alu_result (alu_result),
		.md_result  (md_result),
		.stall      (stall),
		.out_valid  (out_valid),
		.out_result (out_result),
		.out_dest   (out_dest)
	);

endmodule : lc3b_execute_top

// File: design/lc3b_exmem_reg.sv
`timescale 1ns/1ps
`include "lc3b_macros.svh"

module lc3b_exmem_reg
(
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    ex_valid,
	input  lc3b_pkg::lc3b_aluop     ex_aluop,
	input  logic [`LC3B_REGNUM-1:0] ex_dest,
	input  logic [`LC3B_WORD-1:0]   alu_result,
	input  logic [`LC3B_WORD-1:0]   md_result,
	input  logic                    stall,
	output logic                    out_valid,
	output logic [`LC3B_WORD-1:0]   out_result,
	output logic [`LC3B_REGNUM-1:0] out_dest
);

	logic is_md;                         // result comes from the multicycle unit
	logic [`LC3B_WORD-1:0] ex_result;
	logic capture;                       // an instruction leaves execute this edge

	assign is_md = (ex_aluop == lc3b_pkg::alu_mult) || (ex_aluop == lc3b_pkg::alu_div);
	assign ex_result = is_md ? md_result : alu_result;
	assign capture = ex_valid && !stall;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			out_valid <= 1'b0;
		end
		else
		begin
			out_valid <= capture; // bubble while stalled, so one pulse per op
		end
	end

	always_ff @(posedge clk)
	begin
		if (capture)
		begin
			out_result <= ex_result;
			out_dest <= ex_dest;    // old values kept across bubbles
		end
	end

endmodule : lc3b_exmem_reg

// File: design/lc3b_idex_reg.sv
`timescale 1ns/1ps
`include "lc3b_macros.svh"

module lc3b_idex_reg
(
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    in_valid,
	input  lc3b_pkg::lc3b_aluop     in_aluop,
	input  logic [`LC3B_WORD-1:0]   in_sr1,
	input  logic [`LC3B_WORD-1:0]   in_sr2,
	input  logic [`LC3B_REGNUM-1:0] in_dest,
	input  logic                    stall,
	output logic                    ex_valid,
	output lc3b_pkg::lc3b_aluop     ex_aluop,
	output logic [`LC3B_WORD-1:0]   ex_sr1,
	output logic [`LC3B_WORD-1:0]   ex_sr2,
	output logic [`LC3B_REGNUM-1:0] ex_dest
);

	// control half, cleared by reset
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			ex_valid <= 1'b0;
			ex_aluop <= lc3b_pkg::alu_add; // harmless op, keeps stall low
		end
		else if (!stall)
		begin
			ex_valid <= in_valid;          // bubble when nothing issued
			ex_aluop <= in_aluop;
		end
	end

	// operand half, held with the control while stalled
	always_ff @(posedge clk)
	begin
		if (!stall)
		begin
			ex_sr1 <= in_sr1;
			ex_sr2 <= in_sr2;
			ex_dest <= in_dest;
		end
	end

endmodule : lc3b_idex_reg

// File: design/lc3b_macros.svh
`ifndef LC3B_MACROS_SVH
`define LC3B_MACROS_SVH

// lc3b datapath word
`define LC3B_WORD 16

// destination register number, r0 to r7
`define LC3B_REGNUM 3

// shift amount field taken from the low bits of b
`define LC3B_SHAMT 4

// all-zero data word
`define LC3B_ZERO 16'h0000

`endif

// File: design/lc3b_pkg.sv
package lc3b_pkg;

	// operation codes carried from decode into the execute stage
	typedef enum logic [3:0]
	{
		alu_add  = 4'd0, // a + b
		alu_and  = 4'd1, // bitwise and
		alu_not  = 4'd2, // invert a
		alu_pass = 4'd3, // forward b unchanged
		alu_sll  = 4'd4, // shift a left by b[3:0]
		alu_srl  = 4'd5, // logical right shift
		alu_sra  = 4'd6, // arithmetic right shift, sign fills
		alu_mult = 4'd7, // multicycle, low 16 bits of product
		alu_div  = 4'd8  // multicycle, quotient toward zero
	} lc3b_aluop;

	// sequencer of the multiply/divide unit
	// st_load grabs magnitudes, st_iterate loops, st_done waits for flow
	typedef enum logic [1:0]
	{
		st_load    = 2'd0, // idle and load slot
		st_iterate = 2'd1, // one add or subtract per cycle
		st_done    = 2'd2  // result ready, held until flow
	} muldiv_state;

endpackage : lc3b_pkg

// File: run.sh
#!/bin/sh
# build the execute stage testbench with verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module lc3b_execute_tb \
	-Mdir obj_dir -o lc3b_execute_sim > build.log 2>&1
if [ $? -ne 0 ]; then
	echo "verilator build failed, see build.log"
	exit 1
fi

./obj_dir/lc3b_execute_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if grep -qx "NO ERRORS" sim.log; then
	echo "simulation passed"
	exit 0
fi
echo "simulation failed"
exit 1

// File: verification/lc3b_execute_assertions.sv
`timescale 1ns/1ps

module lc3b_execute_assertions
(
	input logic                  clk,
	input logic                  rst_n,
	input logic                  out_valid,
	input logic                  stall,
	input lc3b_pkg::muldiv_state md_state
);

	// a stalled edge only lets a bubble into ex/mem
	stalled_no_output: assert property (@(posedge clk) disable iff (!rst_n) stall |=> !out_valid)
		else $error("out_valid followed a stalled cycle");

	reset_no_stall: assert property (@(posedge clk) !rst_n |-> !stall)
		else $error("stall high during reset");

	release_quiet: assert property (@(posedge clk) $rose(rst_n) |-> !out_valid)
		else $error("out_valid high right after reset release");

	iterate_stalls: assert property (@(posedge clk) disable iff (!rst_n)
		(md_state == lc3b_pkg::st_iterate) |-> stall)
		else $error("stall low while the unit iterates");

endmodule : lc3b_execute_assertions

bind lc3b_execute_top lc3b_execute_assertions i_execute_assertions
(
	.clk       (clk),
	.rst_n     (rst_n),
	.out_valid (out_valid),
	.stall     (stall),
	.md_state  (i_div_mult_unit.state)
);

// File: verification/lc3b_execute_tb.sv
`timescale 1ns/1ps
`include "lc3b_macros.svh"

module lc3b_execute_tb;

	localparam int timeout_cycles = 200; // longest mult or div takes about 65 cycles

	typedef struct packed
	{
		logic [`LC3B_WORD-1:0]   result;
		logic [`LC3B_REGNUM-1:0] dest;
		logic                    single;      // one-cycle op, fixed latency
		int                      accepted_at; // negedge count at acceptance
	} pending_t;

	logic clk;
	logic rst_n;
	logic in_valid;
	lc3b_pkg::lc3b_aluop in_aluop;
	logic [`LC3B_WORD-1:0] in_sr1;
	logic [`LC3B_WORD-1:0] in_sr2;
	logic [`LC3B_REGNUM-1:0] in_dest;
	logic flow;
	logic out_valid;
	logic [`LC3B_WORD-1:0] out_result;
	logic [`LC3B_REGNUM-1:0] out_dest;
	logic stall;

	pending_t pending_q[$];      // accepted, not yet seen at the output
	int cycle = 0;               // falling edges since time zero
	int value_errors = 0;
	int protocol_errors = 0;     // ordering and latency, from the comparing process
	int run_errors = 0;          // timeouts and sequence checks
	int stall_rises = 0;
	int md_issued = 0;
	bit stall_seen = 1'b0;
	bit timed_out = 1'b0;
	bit jitter_flow = 1'b0;      // randomize flow while an op waits

	lc3b_execute_top i_dut
	(
		.clk        (clk),
		.rst_n      (rst_n),
		.in_valid   (in_valid),
		.in_aluop   (in_aluop),
		.in_sr1     (in_sr1),
		.in_sr2     (in_sr2),
		.in_dest    (in_dest),
		.flow       (flow),
		.out_valid  (out_valid),
		.out_result (out_result),
		.out_dest   (out_dest),
		.stall      (stall)
	);

	initial
	begin
		clk = 1'b0;
		forever
		begin
			#10 clk = ~clk; // 20 ns period
		end
	end

	// expected result worked out on plain signed integers
	function automatic logic [`LC3B_WORD-1:0] expected_result(lc3b_pkg::lc3b_aluop op,
		logic [`LC3B_WORD-1:0] a, logic [`LC3B_WORD-1:0] b);
		int sa;
		int sb;
		int full;
		sa = int'($signed(a));
		sb = int'($signed(b));
		case (op)
			lc3b_pkg::alu_add:  full = sa + sb;
			lc3b_pkg::alu_and:  full = int'(a & b);
			lc3b_pkg::alu_not:  full = int'(~a);
			lc3b_pkg::alu_pass: full = sb;
			lc3b_pkg::alu_sll:  full = int'(a) << b[3:0];
			lc3b_pkg::alu_srl:  full = int'(a) >> b[3:0]; // zero extended first
			lc3b_pkg::alu_sra:  full = sa >>> b[3:0];     // sign extended first
			lc3b_pkg::alu_mult: full = sa * sb;           // low half is the signed product
			lc3b_pkg::alu_div:  full = (sb == 0) ? 0 : sa / sb; // truncates toward zero
			default:            full = 0;
		endcase
		return full[`LC3B_WORD-1:0];
	endfunction

	function automatic logic [`LC3B_WORD-1:0] with_sign(bit negative, int magnitude);
		logic [`LC3B_WORD-1:0] m;
		m = magnitude[`LC3B_WORD-1:0];
		return negative ? -m : m;
	endfunction

	task automatic note_failure(string what);
		run_errors++;
		$display("%s, at %0t", what, $time);
	endtask

	task automatic value_mismatch(string name, int got, int want);
		value_errors++;
		$display("error at %0t: %s = %0h, expected %0h", $time, name, got, want);
	endtask

	// present one instruction and hold it until an edge with stall low takes it
	task automatic issue_op(lc3b_pkg::lc3b_aluop op, logic [`LC3B_WORD-1:0] a,
		logic [`LC3B_WORD-1:0] b, logic [`LC3B_REGNUM-1:0] dest);
		int waited;
		if (timed_out)
			return;
		in_valid = 1'b1;
		in_aluop = op;
		in_sr1 = a;
		in_sr2 = b;
		in_dest = dest;
		@(negedge clk);
		for (waited = 0; stall && (waited < timeout_cycles); waited++)
		begin
			@(posedge clk);
			#2;
			if (jitter_flow)
				flow = ($urandom_range(3, 0) != 0); // one cycle in four holds a finished op
			@(negedge clk);
		end
		if (stall)
		begin
			timed_out = 1'b1;
			note_failure("stall never dropped while an instruction waited to issue");
		end
		@(posedge clk);
		#2;
		in_valid = 1'b0; // taken at that edge
	endtask

	task automatic wait_drain();
		int waited;
		if (timed_out)
			return;
		for (waited = 0; (pending_q.size() != 0) && (waited < timeout_cycles); waited++)
			@(posedge clk);
		if (pending_q.size() != 0)
		begin
			timed_out = 1'b1;
			note_failure("results were still missing when the drain wait ran out");
		end
		@(posedge clk);
		#2;
	endtask

	// comparing process, sampled at the falling edge where inputs and outputs are settled
	always @(negedge clk)
	begin : compare_outputs
		pending_t head;
		cycle++;
		if (rst_n)
		begin
			if (stall && !stall_seen)
				stall_rises++;
			stall_seen = stall;
			if (out_valid)
			begin
				assert (pending_q.size() != 0)
				else
				begin
					protocol_errors++;
					$display("out_valid at %0t with no instruction outstanding", $time);
				end
				if (pending_q.size() != 0)
				begin
					head = pending_q.pop_front(); // results leave in issue order
					assert (out_result === head.result)
					else value_mismatch("out_result", out_result, head.result);
					assert (out_dest === head.dest)
					else value_mismatch("out_dest", out_dest, head.dest);
					// counted from the falling edge before the taking edge
					assert (!head.single || ((cycle - head.accepted_at) == 2))
					else
					begin
						protocol_errors++;
						$display("result for r%0d not one edge after acceptance, at %0t",
							head.dest, $time);
					end
				end
			end
			if (in_valid && !stall) // the next rising edge takes it
			begin
				head.result = expected_result(in_aluop, in_sr1, in_sr2);
				head.dest = in_dest;
				head.single = (in_aluop != lc3b_pkg::alu_mult) && (in_aluop != lc3b_pkg::alu_div);
				head.accepted_at = cycle;
				md_issued += head.single ? 0 : 1;
				pending_q.push_back(head);
			end
		end
	end

	initial
	begin
		int seed_ret;
		int dsr;
		int q;
		lc3b_pkg::lc3b_aluop op;
		seed_ret = $urandom(12614);
		rst_n = 1'b0;
		in_valid = 1'b0;
		in_aluop = lc3b_pkg::alu_add;
		in_sr1 = `LC3B_ZERO;
		in_sr2 = `LC3B_ZERO;
		in_dest = '0;
		flow = 1'b1;
		repeat (16) @(posedge clk);
		#2;
		rst_n = 1'b1;
		@(posedge clk);
		#2;
		for (int i = 0; i < 60; i++) // single-cycle ops back to back
			issue_op(lc3b_pkg::lc3b_aluop'(4'($urandom_range(6, 0))), 16'($urandom),
				16'($urandom), 3'(i));
		wait_drain();
		for (int s = 0; s < 4; s++) // multiply, s picks the two signs
		begin
			issue_op(lc3b_pkg::alu_mult, with_sign(s[0], $urandom_range(60, 1)),
				with_sign(s[1], $urandom_range(60, 1)), 3'(s));
			issue_op(lc3b_pkg::alu_mult, with_sign(s[0], $urandom_range(60, 1)), `LC3B_ZERO,
				3'(s + 4));
			issue_op(lc3b_pkg::alu_mult, `LC3B_ZERO, with_sign(s[1], $urandom_range(60, 1)),
				3'(s));
		end
		wait_drain();
		for (int s = 0; s < 4; s++) // divide, exact, inexact and by zero
		begin
			dsr = $urandom_range(10, 2);
			q = $urandom_range(5, 0);
			issue_op(lc3b_pkg::alu_div, with_sign(s[0], dsr * q), with_sign(s[1], dsr), 3'(s));
			issue_op(lc3b_pkg::alu_div, with_sign(s[0], dsr * q + $urandom_range(dsr - 1, 1)),
				with_sign(s[1], dsr), 3'(s + 4));
			issue_op(lc3b_pkg::alu_div, with_sign(s[0], $urandom_range(60, 0)), `LC3B_ZERO,
				3'(s));
		end
		wait_drain();
		flow = 1'b0; // finished multiply must sit in the unit
		issue_op(lc3b_pkg::alu_mult, with_sign(1, $urandom_range(60, 1)),
			with_sign(0, $urandom_range(60, 1)), 3'd5);
		for (int i = 0; i < 80; i++)
		begin
			@(negedge clk);
			assert (stall && !out_valid)
			else note_failure("stall dropped or out_valid rose while flow was low");
			@(posedge clk);
			#2;
		end
		flow = 1'b1;
		wait_drain();
		jitter_flow = 1'b1; // mixed stream with the hazard unit holding now and then
		for (int i = 0; i < 40; i++)
		begin
			op = lc3b_pkg::lc3b_aluop'(4'($urandom_range(8, 0)));
			if ((op == lc3b_pkg::alu_mult) || (op == lc3b_pkg::alu_div))
				issue_op(op, with_sign($urandom_range(1, 0), $urandom_range(60, 0)),
					with_sign($urandom_range(1, 0), $urandom_range(60, 0)), 3'(i));
			else
				issue_op(op, 16'($urandom), 16'($urandom), 3'(i));
		end
		jitter_flow = 1'b0;
		flow = 1'b1;
		wait_drain();
		assert (stall_rises == md_issued)
		else note_failure($sformatf("stall rose %0d times for %0d multiply or divide ops",
			stall_rises, md_issued));
		$display("value errors %0d, protocol errors %0d, run errors %0d",
			value_errors, protocol_errors, run_errors);
		if ((value_errors + protocol_errors + run_errors) == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule : lc3b_execute_tb

// File: vlog.f
+incdir+design
design/lc3b_pkg.sv
design/lc3b_alu.sv
design/lc3b_div_mult_unit.sv
design/lc3b_idex_reg.sv
design/lc3b_exmem_reg.sv
design/lc3b_execute_top.sv
verification/lc3b_execute_assertions.sv
verification/lc3b_execute_tb.sv
